//--- kbd_pkg.sv
package kbd_pkg;

   // ps/2 frame: start, 8 data bits lsb first, odd parity, stop
   localparam int ps2_frame_bits = 11;
   localparam int ps2_data_lsb   = 1;

   typedef logic [7:0] scancode_t;

   // prefixes
   localparam scancode_t sc_extended = 8'he0;
   localparam scancode_t sc_break    = 8'hf0;

   // modifier keys, short codes only
   localparam scancode_t sc_lshift = 8'h12;
   localparam scancode_t sc_rshift = 8'h59;

   // arrows, sent behind the E0 prefix
   localparam scancode_t sc_up    = 8'h75;
   localparam scancode_t sc_down  = 8'h72;
   localparam scancode_t sc_left  = 8'h6b;
   localparam scancode_t sc_right = 8'h74;

   // editing keys
   localparam scancode_t sc_backspace = 8'h66;
   localparam scancode_t sc_return    = 8'h5a;

   // one decoded make event, 11 bits
   typedef struct packed {
      logic      valid;
      logic      extended;
      logic      shift;
      scancode_t code;
   } key_event_t;

endpackage

//--- screen_pkg.sv
package screen_pkg;

   // text screen geometry
   localparam int screen_rows = 16;
   localparam int screen_cols = 64;

   typedef logic [3:0] row_t;
   typedef logic [5:0] col_t;

   // saturation limits for the cursor
   localparam row_t last_row = row_t'(screen_rows - 1);
   localparam col_t last_col = col_t'(screen_cols - 1);

   typedef struct packed {
      row_t row;
      col_t col;
   } screen_pos_t;

   // row above column, so the flat view is row * 64 + col
   typedef union packed {
      logic [9:0]  flat;
      screen_pos_t pos;
   } screen_addr_u;

   typedef enum logic [2:0] {
      cmd_none,
      cmd_up,
      cmd_down,
      cmd_left,
      cmd_right,
      cmd_advance,
      cmd_backspace,
      cmd_newline
   } cursor_cmd_e;

   typedef struct packed {
      logic         valid;
      screen_addr_u addr;
      logic [7:0]   ch;
   } char_write_t;

endpackage

//--- ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
   input  logic               fast_clk,
   input  logic               clr,
   input  logic               ps2_clk,
   input  logic               ps2_data,
   output logic               byte_valid,
   output kbd_pkg::scancode_t byte_code
);

   // both ps/2 lines idle high
   logic [1:0] clk_sync_q;
   logic [1:0] data_sync_q;
   logic       clk_prev_q;
   logic       clk_rise;

   logic [kbd_pkg::ps2_frame_bits-1:0] frame_q;
   logic [kbd_pkg::ps2_frame_bits-1:0] frame_next;
   logic [3:0]                         bit_cnt_q;
   logic                               frame_done;

   always_ff @(posedge fast_clk or posedge clr) begin
      if (clr) begin
         clk_sync_q  <= 2'b11;
         data_sync_q <= 2'b11;
         clk_prev_q  <= 1'b1;
      end else begin
         clk_sync_q  <= {clk_sync_q[0], ps2_clk};
         data_sync_q <= {data_sync_q[0], ps2_data};
         clk_prev_q  <= clk_sync_q[1];
      end
   end

   assign clk_rise = clk_sync_q[1] & ~clk_prev_q;

   // lsb first, new bits enter at the top
   assign frame_next = {data_sync_q[1], frame_q[kbd_pkg::ps2_frame_bits-1:1]};
   assign frame_done = clk_rise && (bit_cnt_q == 4'(kbd_pkg::ps2_frame_bits - 1));

   always_ff @(posedge fast_clk or posedge clr) begin
      if (clr) begin
         bit_cnt_q  <= '0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= frame_done;
         if (frame_done) begin
            bit_cnt_q <= '0;
         end else if (clk_rise) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
         end
      end
   end

   // parity and stop bit are taken but not checked
   always_ff @(posedge fast_clk) begin
      if (clk_rise) begin
         frame_q <= frame_next;
      end
      if (frame_done) begin
         byte_code <= frame_next[kbd_pkg::ps2_data_lsb +: 8];
      end
   end

endmodule

//--- scancode_decoder.sv
`timescale 1ns/100ps

module scancode_decoder (
   input  logic                fast_clk,
   input  logic                clr,
   input  logic                byte_valid,
   input  kbd_pkg::scancode_t  byte_code,
   output kbd_pkg::key_event_t key_event
);

   // prefix state for the code in progress
   logic extended_q;
   logic break_q;
   // held modifier state
   logic lshift_q;
   logic rshift_q;

   logic is_prefix;
   logic is_lshift;
   logic is_rshift;
   logic emit;

   logic               ev_valid_q;
   logic               ev_extended_q;
   logic               ev_shift_q;
   kbd_pkg::scancode_t ev_code_q;

   assign is_prefix = (byte_code == kbd_pkg::sc_extended) || (byte_code == kbd_pkg::sc_break);

   // E0 12 is a fake shift from some keys, not a real modifier
   assign is_lshift = !extended_q && (byte_code == kbd_pkg::sc_lshift);
   assign is_rshift = !extended_q && (byte_code == kbd_pkg::sc_rshift);

   // only make codes of non-modifier keys become events
   assign emit = byte_valid && !is_prefix && !break_q && !is_lshift && !is_rshift;

   always_ff @(posedge fast_clk or posedge clr) begin
      if (clr) begin
         extended_q <= 1'b0;
         break_q    <= 1'b0;
         lshift_q   <= 1'b0;
         rshift_q   <= 1'b0;
         ev_valid_q <= 1'b0;
      end else begin
         ev_valid_q <= emit;
         if (byte_valid) begin
            if (byte_code == kbd_pkg::sc_extended) begin
               extended_q <= 1'b1;
            end else if (byte_code == kbd_pkg::sc_break) begin
               break_q <= 1'b1;
            end else begin
               // code complete, prefixes consumed
               extended_q <= 1'b0;
               break_q    <= 1'b0;
               if (is_lshift) begin
                  lshift_q <= !break_q;
               end
               if (is_rshift) begin
                  rshift_q <= !break_q;
               end
            end
         end
      end
   end

   always_ff @(posedge fast_clk) begin
      if (emit) begin
         ev_extended_q <= extended_q;
         ev_shift_q    <= lshift_q | rshift_q;
         ev_code_q     <= byte_code;
      end
   end

   always_comb begin
      key_event.valid    = ev_valid_q;
      key_event.extended = ev_extended_q;
      key_event.shift    = ev_shift_q;
      key_event.code     = ev_code_q;
   end

endmodule

//--- keymap_rom.sv
`timescale 1ns/100ps

module keymap_rom (
   input  kbd_pkg::scancode_t code,
   input  logic               shift,
   output logic [7:0]         ch,
   output logic               printable
);

   logic [7:0] plain_ch;
   logic [7:0] shifted_ch;
   logic       shifted_hit;
   logic       is_letter;

   // plain table, us layout, zero means no printable key
   always_comb begin
      case (code)
         8'h0e: plain_ch = 8'h60;
         8'h16: plain_ch = "1";
         8'h1e: plain_ch = "2";
         8'h26: plain_ch = "3";
         8'h25: plain_ch = "4";
         8'h2e: plain_ch = "5";
         8'h36: plain_ch = "6";
         8'h3d: plain_ch = "7";
         8'h3e: plain_ch = "8";
         8'h46: plain_ch = "9";
         8'h45: plain_ch = "0";
         8'h4e: plain_ch = "-";
         8'h55: plain_ch = "=";
         8'h5d: plain_ch = "\\";
         8'h15: plain_ch = "q";
         8'h1d: plain_ch = "w";
         8'h24: plain_ch = "e";
         8'h2d: plain_ch = "r";
         8'h2c: plain_ch = "t";
         8'h35: plain_ch = "y";
         8'h3c: plain_ch = "u";
         8'h43: plain_ch = "i";
         8'h44: plain_ch = "o";
         8'h4d: plain_ch = "p";
         8'h54: plain_ch = "[";
         8'h5b: plain_ch = "]";
         8'h1c: plain_ch = "a";
         8'h1b: plain_ch = "s";
         8'h23: plain_ch = "d";
         8'h2b: plain_ch = "f";
         8'h34: plain_ch = "g";
         8'h33: plain_ch = "h";
         8'h3b: plain_ch = "j";
         8'h42: plain_ch = "k";
         8'h4b: plain_ch = "l";
         8'h4c: plain_ch = ";";
         8'h52: plain_ch = "'";
         8'h1a: plain_ch = "z";
         8'h22: plain_ch = "x";
         8'h21: plain_ch = "c";
         8'h2a: plain_ch = "v";
         8'h32: plain_ch = "b";
         8'h31: plain_ch = "n";
         8'h3a: plain_ch = "m";
         8'h41: plain_ch = ",";
         8'h49: plain_ch = ".";
         8'h4a: plain_ch = "/";
         8'h29: plain_ch = " ";
         default: plain_ch = 8'h00;
      endcase
   end

   // shifted table for the symbol keys, letters are folded below
   always_comb begin
      shifted_hit = 1'b1;
      case (code)
         8'h0e: shifted_ch = "~";
         8'h16: shifted_ch = "!";
         8'h1e: shifted_ch = "@";
         8'h26: shifted_ch = "#";
         8'h25: shifted_ch = "$";
         8'h2e: shifted_ch = "%";
         8'h36: shifted_ch = "^";
         8'h3d: shifted_ch = "&";
         8'h3e: shifted_ch = "*";
         8'h46: shifted_ch = "(";
         8'h45: shifted_ch = ")";
         8'h4e: shifted_ch = "_";
         8'h55: shifted_ch = "+";
         8'h5d: shifted_ch = "|";
         8'h54: shifted_ch = "{";
         8'h5b: shifted_ch = "}";
         8'h4c: shifted_ch = ":";
         8'h52: shifted_ch = "\"";
         8'h41: shifted_ch = "<";
         8'h49: shifted_ch = ">";
         8'h4a: shifted_ch = "?";
         default: begin
            shifted_ch  = 8'h00;
            shifted_hit = 1'b0;
         end
      endcase
   end

   assign is_letter = (plain_ch >= "a") && (plain_ch <= "z");
   assign printable = (plain_ch != 8'h00);

   always_comb begin
      if (!shift) begin
         ch = plain_ch;
      end else if (shifted_hit) begin
         ch = shifted_ch;
      end else if (is_letter) begin
         // upper case sits 0x20 below lower case
         ch = plain_ch - 8'h20;
      end else begin
         ch = plain_ch;
      end
   end

endmodule

//--- cursor_register.sv
`timescale 1ns/100ps

module cursor_register (
   input  logic                     fast_clk,
   input  logic                     clr,
   input  screen_pkg::cursor_cmd_e  cmd,
   output screen_pkg::screen_addr_u cursor
);

   screen_pkg::screen_addr_u pos_q;

   // every move saturates at the screen edge
   always_ff @(posedge fast_clk or posedge clr) begin
      if (clr) begin
         pos_q.flat <= '0;
      end else begin
         case (cmd)
            screen_pkg::cmd_up: begin
               if (pos_q.pos.row != '0) begin
                  pos_q.pos.row <= pos_q.pos.row - 4'd1;
               end
            end
            screen_pkg::cmd_down: begin
               if (pos_q.pos.row != screen_pkg::last_row) begin
                  pos_q.pos.row <= pos_q.pos.row + 4'd1;
               end
            end
            screen_pkg::cmd_left, screen_pkg::cmd_backspace: begin
               if (pos_q.pos.col != '0) begin
                  pos_q.pos.col <= pos_q.pos.col - 6'd1;
               end
            end
            screen_pkg::cmd_right, screen_pkg::cmd_advance: begin
               if (pos_q.pos.col != screen_pkg::last_col) begin
                  pos_q.pos.col <= pos_q.pos.col + 6'd1;
               end
            end
            screen_pkg::cmd_newline: begin
               pos_q.pos.col <= '0;
               // bottom row stays, no scrolling
               if (pos_q.pos.row != screen_pkg::last_row) begin
                  pos_q.pos.row <= pos_q.pos.row + 4'd1;
               end
            end
            default: begin
               pos_q <= pos_q;
            end
         endcase
      end
   end

   assign cursor = pos_q;

endmodule

//--- line_editor.sv
`timescale 1ns/100ps

module line_editor (
   input  logic                     fast_clk,
   input  logic                     clr,
   input  kbd_pkg::key_event_t      key_event,
   input  screen_pkg::screen_addr_u cursor,
   output screen_pkg::cursor_cmd_e  cmd,
   output screen_pkg::char_write_t  char_wr
);

   logic [7:0]              map_ch;
   logic                    map_printable;
   logic                    write_d;
   screen_pkg::cursor_cmd_e cmd_d;

   logic                     wr_valid_q;
   screen_pkg::screen_addr_u wr_addr_q;
   logic [7:0]               wr_ch_q;

   keymap_rom u_keymap (
      .code      (key_event.code),
      .shift     (key_event.shift),
      .ch        (map_ch),
      .printable (map_printable)
   );

   always_comb begin
      write_d = 1'b0;
      cmd_d   = screen_pkg::cmd_none;
      if (key_event.valid) begin
         if (key_event.extended) begin
            // only the arrows mean something behind E0
            case (key_event.code)
               kbd_pkg::sc_up:    cmd_d = screen_pkg::cmd_up;
               kbd_pkg::sc_down:  cmd_d = screen_pkg::cmd_down;
               kbd_pkg::sc_left:  cmd_d = screen_pkg::cmd_left;
               kbd_pkg::sc_right: cmd_d = screen_pkg::cmd_right;
               default:           cmd_d = screen_pkg::cmd_none;
            endcase
         end else if (map_printable) begin
            write_d = 1'b1;
            cmd_d   = screen_pkg::cmd_advance;
         end else if (key_event.code == kbd_pkg::sc_backspace) begin
            cmd_d = screen_pkg::cmd_backspace;
         end else if (key_event.code == kbd_pkg::sc_return) begin
            cmd_d = screen_pkg::cmd_newline;
         end
      end
   end

   always_ff @(posedge fast_clk or posedge clr) begin
      if (clr) begin
         wr_valid_q <= 1'b0;
         cmd        <= screen_pkg::cmd_none;
      end else begin
         wr_valid_q <= write_d;
         cmd        <= cmd_d;
      end
   end

   // write lands at the cursor before the advance takes effect
   always_ff @(posedge fast_clk) begin
      if (write_d) begin
         wr_addr_q <= cursor;
         wr_ch_q   <= map_ch;
      end
   end

   always_comb begin
      char_wr.valid = wr_valid_q;
      char_wr.addr  = wr_addr_q;
      char_wr.ch    = wr_ch_q;
   end

endmodule

//--- kbd_terminal_top.sv
`timescale 1ns/100ps

module kbd_terminal_top (
   input  logic                     fast_clk,
   input  logic                     clr,
   input  logic                     ps2_clk,
   input  logic                     ps2_data,
   output screen_pkg::char_write_t  char_wr,
   output screen_pkg::screen_addr_u cursor
);

   logic                    byte_valid;
   kbd_pkg::scancode_t      byte_code;
   kbd_pkg::key_event_t     key_event;
   screen_pkg::cursor_cmd_e cmd;

   ps2_receiver u_receiver (
      .fast_clk   (fast_clk),
      .clr        (clr),
      .ps2_clk    (ps2_clk),
      .ps2_data   (ps2_data),
      .byte_valid (byte_valid),
      .byte_code  (byte_code)
   );

   scancode_decoder u_decoder (
      .fast_clk   (fast_clk),
      .clr        (clr),
      .byte_valid (byte_valid),
      .byte_code  (byte_code),
      .key_event  (key_event)
   );

   line_editor u_editor (
      .fast_clk  (fast_clk),
      .clr       (clr),
      .key_event (key_event),
      .cursor    (cursor),
      .cmd       (cmd),
      .char_wr   (char_wr)
   );

   cursor_register u_cursor (
      .fast_clk (fast_clk),
      .clr      (clr),
      .cmd      (cmd),
      .cursor   (cursor)
   );

endmodule

//--- kbd_terminal_properties.sv
`timescale 1ns/100ps

module kbd_terminal_properties (
   input logic                     fast_clk,
   input logic                     clr,
   input screen_pkg::char_write_t  char_wr,
   input screen_pkg::screen_addr_u cursor,
   input screen_pkg::cursor_cmd_e  cmd
);

   // one row or one column, either direction, or no move at all
   function automatic logic one_step(input screen_pkg::screen_addr_u now,
                                     input screen_pkg::screen_addr_u was);
      int dr;
      int dc;
      dr = int'(now.pos.row) - int'(was.pos.row);
      dc = int'(now.pos.col) - int'(was.pos.col);
      return (dr == 0 && dc >= -1 && dc <= 1)
          || (dc == 0 && (dr == 1 || dr == -1));
   endfunction

   a_write_single_cycle: assert property (
      @(posedge fast_clk) disable iff (clr) char_wr.valid |=> !char_wr.valid
   ) else $error("char_wr.valid held for two cycles");

   a_reset_state: assert property (
      @(posedge fast_clk) (clr && $past(clr)) |-> (cursor.flat == 10'd0 && !char_wr.valid)
   ) else $error("cursor or char_wr.valid not cleared during clr");

   // newline jumps to column 0 while every other command is a single step
   a_cursor_step: assert property (
      @(posedge fast_clk) disable iff (clr)
      ($past(cmd) != screen_pkg::cmd_newline) |-> one_step(cursor, $past(cursor))
   ) else $error("cursor moved more than one step in a cycle");

endmodule

bind kbd_terminal_top kbd_terminal_properties u_properties (
   .fast_clk (fast_clk),
   .clr      (clr),
   .char_wr  (char_wr),
   .cursor   (cursor),
   .cmd      (cmd)
);

//--- tb_kbd_terminal.sv
`timescale 1ns/100ps

module tb_kbd_terminal;

   localparam int half_bit_cycles = 40;
   localparam int frame_cycles    = 2 * half_bit_cycles * kbd_pkg::ps2_frame_bits;
   localparam int clk_period_ns   = 10;
   // worst case frame count over all tests, the arrow sweep dominates
   localparam int frame_budget    = 340;
   localparam int watchdog_ns     = frame_budget * frame_cycles * clk_period_ns + 5000;

   logic                     fast_clk;
   logic                     clr;
   logic                     ps2_clk;
   logic                     ps2_data;
   screen_pkg::char_write_t  char_wr;
   screen_pkg::screen_addr_u cursor;

   screen_pkg::char_write_t wr_q[$];
   logic [31:0]             lfsr;
   int                      exp_row;
   int                      exp_col;
   int                      errors;
   int                      checks;
   int                      tests;

   // us layout letter keys in qwerty order
   logic [7:0] letter_codes [26] = '{
      8'h15, 8'h1d, 8'h24, 8'h2d, 8'h2c, 8'h35, 8'h3c, 8'h43, 8'h44, 8'h4d,
      8'h1c, 8'h1b, 8'h23, 8'h2b, 8'h34, 8'h33, 8'h3b, 8'h42, 8'h4b,
      8'h1a, 8'h22, 8'h21, 8'h2a, 8'h32, 8'h31, 8'h3a
   };
   string lower_keys = "qwertyuiopasdfghjklzxcvbnm";
   string upper_keys = "QWERTYUIOPASDFGHJKLZXCVBNM";

   kbd_terminal_top DUT (
      .fast_clk (fast_clk),
      .clr      (clr),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .char_wr  (char_wr),
      .cursor   (cursor)
   );

   initial begin
      fast_clk = 1'b0;
      forever #5 fast_clk = ~fast_clk;
   end

   // collect every character write, sampled away from the rising edge
   always @(negedge fast_clk) begin
      if (!clr && char_wr.valid) begin
         wr_q.push_back(char_wr);
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++) begin
         lfsr  = lfsr_next(lfsr);
         value = (value << 1) | int'(lfsr[0]);
      end
   endtask

   function automatic int clamp(input int v, input int hi);
      return (v < 0) ? 0 : ((v > hi) ? hi : v);
   endfunction

   function automatic screen_pkg::screen_addr_u addr_of(input int row, input int col);
      screen_pkg::screen_addr_u a;
      a.flat = 10'(row * screen_pkg::screen_cols + col);
      return a;
   endfunction

   // start bit, data lsb first, odd parity, stop bit
   task automatic send_frame(input kbd_pkg::scancode_t code);
      logic [10:0] frame;
      frame = {1'b1, ~^code, code, 1'b0};
      for (int i = 0; i < kbd_pkg::ps2_frame_bits; i++) begin
         @(negedge fast_clk);
         ps2_data = frame[0];
         ps2_clk  = 1'b0;
         frame    = frame >> 1;
         repeat (half_bit_cycles) @(negedge fast_clk);
         ps2_clk = 1'b1;
         repeat (half_bit_cycles - 1) @(negedge fast_clk);
      end
   endtask

   task automatic compare_char_write(input screen_pkg::char_write_t exp);
      screen_pkg::char_write_t got;
      int                      waited;
      waited = 0;
      checks++;
      while (wr_q.size() == 0 && waited < 100) begin
         @(negedge fast_clk);
         waited++;
      end
      if (wr_q.size() == 0) begin
         errors++;
         $display("no character write arrived for '%c' within %0d cycles", exp.ch, waited);
      end else begin
         got = wr_q.pop_front();
         if (got.addr.flat != exp.addr.flat || got.ch != exp.ch) begin
            errors++;
            $display("Error at %0d ns: char write addr %0d ch %02h, expected addr %0d ch %02h",
                     $time, got.addr.flat, got.ch, exp.addr.flat, exp.ch);
         end
      end
   endtask

   task automatic compare_cursor(input screen_pkg::screen_addr_u exp);
      checks++;
      if (cursor.pos.row != exp.pos.row || cursor.pos.col != exp.pos.col) begin
         errors++;
         $display("Error at %0d ns: cursor row %0d col %0d, expected row %0d col %0d",
                  $time, cursor.pos.row, cursor.pos.col, exp.pos.row, exp.pos.col);
      end
   endtask

   task automatic check_no_write(input string what);
      checks++;
      if (wr_q.size() != 0) begin
         errors++;
         $display("a character write appeared after %s, none was expected", what);
         wr_q.delete();
      end
   endtask

   task automatic type_key(input kbd_pkg::scancode_t code, input logic [7:0] ch);
      screen_pkg::char_write_t exp;
      exp.valid = 1'b1;
      exp.addr  = addr_of(exp_row, exp_col);
      exp.ch    = ch;
      send_frame(code);
      compare_char_write(exp);
      exp_col = clamp(exp_col + 1, screen_pkg::screen_cols - 1);
      compare_cursor(addr_of(exp_row, exp_col));
   endtask

   // prefix 00 means a short code sent alone
   task automatic silent_key(input kbd_pkg::scancode_t prefix, input kbd_pkg::scancode_t code,
                             input int drow, input int dcol, input string what);
      if (prefix != 8'h00) begin
         send_frame(prefix);
      end
      send_frame(code);
      exp_row = clamp(exp_row + drow, screen_pkg::screen_rows - 1);
      exp_col = clamp(exp_col + dcol, screen_pkg::screen_cols - 1);
      check_no_write(what);
      compare_cursor(addr_of(exp_row, exp_col));
   endtask

   task automatic finish_test(input string name, input int start_errors);
      tests++;
      $display("test %s finished with %0d errors", name, errors - start_errors);
   endtask

   task automatic test_lower_case();
      int idx;
      int start_errors;
      start_errors = errors;
      for (int n = 0; n < 8; n++) begin
         take_bits(5, idx);
         idx = idx % 26;
         type_key(letter_codes[idx], lower_keys[idx]);
      end
      finish_test("lower_case", start_errors);
   endtask

   task automatic test_shift();
      int idx;
      int start_errors;
      start_errors = errors;
      silent_key(8'h00, kbd_pkg::sc_lshift, 0, 0, "left shift make");
      for (int n = 0; n < 4; n++) begin
         take_bits(5, idx);
         idx = idx % 26;
         type_key(letter_codes[idx], upper_keys[idx]);
      end
      silent_key(kbd_pkg::sc_break, kbd_pkg::sc_lshift, 0, 0, "left shift break");
      for (int n = 0; n < 2; n++) begin
         take_bits(5, idx);
         idx = idx % 26;
         type_key(letter_codes[idx], lower_keys[idx]);
      end
      silent_key(kbd_pkg::sc_break, letter_codes[idx], 0, 0, "letter break");
      // right shift on a digit key
      silent_key(8'h00, kbd_pkg::sc_rshift, 0, 0, "right shift make");
      type_key(8'h16, "!");
      silent_key(kbd_pkg::sc_break, kbd_pkg::sc_rshift, 0, 0, "right shift break");
      type_key(8'h16, "1");
      finish_test("shift", start_errors);
   endtask

   task automatic test_arrows();
      int start_errors;
      start_errors = errors;
      silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_up, -1, 0, "up at row 0");
      while (exp_col > 0) begin
         silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_left, 0, -1, "left");
      end
      silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_left, 0, -1, "left at column 0");
      while (exp_row < screen_pkg::screen_rows - 1) begin
         silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_down, 1, 0, "down");
      end
      silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_down, 1, 0, "down at row 15");
      while (exp_col < screen_pkg::screen_cols - 1) begin
         silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_right, 0, 1, "right");
      end
      silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_right, 0, 1, "right at column 63");
      while (exp_row > 0) begin
         silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_up, -1, 0, "up");
      end
      silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_up, -1, 0, "up at row 0");
      finish_test("arrows", start_errors);
   endtask

   task automatic test_edit_keys();
      int start_errors;
      start_errors = errors;
      // last column, the advance saturates
      type_key(8'h1c, "a");
      silent_key(8'h00, kbd_pkg::sc_backspace, 0, -1, "backspace");
      silent_key(8'h00, kbd_pkg::sc_backspace, 0, -1, "backspace");
      while (exp_row < screen_pkg::screen_rows - 1) begin
         silent_key(8'h00, kbd_pkg::sc_return, 1, -screen_pkg::screen_cols, "return");
      end
      silent_key(8'h00, kbd_pkg::sc_return, 1, -screen_pkg::screen_cols, "return at row 15");
      silent_key(8'h00, kbd_pkg::sc_backspace, 0, -1, "backspace at column 0");
      finish_test("edit_keys", start_errors);
   endtask

   task automatic test_unknown();
      int start_errors;
      start_errors = errors;
      type_key(8'h1b, "s");
      silent_key(8'h00, 8'h05, 0, 0, "unknown code 05");
      silent_key(8'h00, 8'h76, 0, 0, "unknown code 76");
      silent_key(kbd_pkg::sc_extended, 8'h1c, 0, 0, "extended non-arrow code");
      silent_key(kbd_pkg::sc_extended, kbd_pkg::sc_return, 0, 0, "extended return code");
      // row 15 column 1, flat address 961
      type_key(8'h23, "d");
      finish_test("unknown", start_errors);
   endtask

   initial begin
      clr      = 1'b1;
      ps2_clk  = 1'b1;
      ps2_data = 1'b1;
      lfsr     = 32'h754db19c;
      exp_row  = 0;
      exp_col  = 0;
      errors   = 0;
      checks   = 0;
      tests    = 0;
      repeat (2) @(negedge fast_clk);
      checks++;
      if (char_wr.valid !== 1'b0) begin
         errors++;
         $display("Error at %0d ns: char_wr.valid is not low during clr", $time);
      end
      compare_cursor(addr_of(0, 0));
      clr = 1'b0;
      repeat (5) @(negedge fast_clk);
      test_lower_case();
      test_shift();
      test_arrows();
      test_edit_keys();
      test_unknown();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired, the tests did not finish within %0d ns", watchdog_ns);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- tb.f
kbd_pkg.sv
screen_pkg.sv
ps2_receiver.sv
scancode_decoder.sv
keymap_rom.sv
cursor_register.sv
line_editor.sv
kbd_terminal_top.sv
kbd_terminal_properties.sv
tb_kbd_terminal.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
verilator --binary --timing --assert --top-module tb_kbd_terminal -f tb.f -o sim_tb \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
